//--- compile.f
+incdir+hw
+incdir+testbench
hw/alu_op_pkg.sv
hw/vector_types_pkg.sv
hw/single_cycle_scalar_alu.sv
hw/vector_operand_issue.sv
hw/vector_result_collect.sv
hw/vector_alu_top.sv
testbench/vector_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the vector ALU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module vector_alu_tb \
	-o vsim_vector_alu
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/vsim_vector_alu 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- testbench/alu_reference.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expected results of the vector ALU, one lane and one instruction
// Included inside the testbench module after the package imports
// FTOI is only modeled for exponents below 158
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef ALU_REFERENCE_SVH
`define ALU_REFERENCE_SVH

function automatic logic [31:0] lane_model(input alu_op_t op, input logic [31:0] a,
	input logic [31:0] b);
	logic [31:0] res;
	logic [31:0] mant;
	logic [31:0] mag;
	int fexp;
	int n;
	res = '0;
	case (op)
		OP_OR: res = a | b;
		OP_AND: res = a & b;
		OP_UMINUS: res = 32'd0 - b;
		OP_XOR: res = a ^ b;
		OP_NOT: res = ~b;
		OP_IADD: res = a + b;
		OP_ISUB: res = a - b;
		OP_ASR: res = (b > 32'd31) ? {32{a[31]}} : 32'($signed(a) >>> b[4:0]);
		OP_LSR: res = (b > 32'd31) ? 32'd0 : a >> b[4:0];
		OP_LSL: res = (b > 32'd31) ? 32'd0 : a << b[4:0];
		OP_CLZ:
		begin
			n = 0;
			while (n < 32 && !b[31-n])
				n++;
			res = 32'(n);
		end
		OP_CTZ:
		begin
			n = 0;
			while (n < 32 && !b[n])
				n++;
			res = 32'(n);
		end
		OP_COPY: res = b;
		OP_EQUAL: res = {31'd0, a == b};
		OP_NEQUAL: res = {31'd0, a != b};
		OP_SIGTR: res = {31'd0, $signed(a) > $signed(b)};
		OP_SIGTE: res = {31'd0, $signed(a) >= $signed(b)};
		OP_SILT: res = {31'd0, $signed(a) < $signed(b)};
		OP_SILTE: res = {31'd0, $signed(a) <= $signed(b)};
		OP_UIGTR: res = {31'd0, a > b};
		OP_UIGTE: res = {31'd0, a >= b};
		OP_UILT: res = {31'd0, a < b};
		OP_UILTE: res = {31'd0, a <= b};
		OP_FTOI:
		begin
			// Value is 1.fraction times 2 to the power of exponent minus 127
			fexp = int'(b[30:23]);
			mant = {8'h00, 1'b1, b[22:0]};
			if (fexp < 127)
				mag = 32'd0;
			else if (fexp >= 150)
				mag = mant << (fexp - 150);
			else
				mag = mant >> (150 - fexp);
			res = b[31] ? 32'd0 - mag : mag;
		end
		default: res = '0;
	endcase
	return res;
endfunction

// Returns the compare mask in the top 4 bits above the 128-bit result
function automatic logic [131:0] vector_model(input alu_op_t op, input logic [127:0] a,
	input logic [127:0] b, input logic [3:0] mask, input logic bcast);
	logic [127:0] res;
	logic [3:0] cmp;
	logic [31:0] lane_b;
	logic [31:0] r;
	logic compare;
	compare = (op >= OP_EQUAL) && (op <= OP_UILTE);
	for (int lane = 0; lane < 4; lane++)
	begin
		lane_b = bcast ? b[31:0] : b[lane*32 +: 32];
		r = lane_model(op, a[lane*32 +: 32], lane_b);
		res[lane*32 +: 32] = mask[lane] ? r : a[lane*32 +: 32];
		cmp[lane] = compare && mask[lane] && r[0];
	end
	return {cmp, res};
endfunction

`endif

//--- testbench/vector_alu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the four-lane vector ALU
// Directed opcodes run without output stalls so latency is checked
// Random instructions then run with random output stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vector_alu_config.svh"

module vector_alu_tb;

	import alu_op_pkg::*;
	import vector_types_pkg::*;

	`include "alu_reference.svh"

	localparam int NUM_DIRECTED = 24;
	localparam int NUM_RANDOM = 200;
	localparam int TOTAL = NUM_DIRECTED + NUM_RANDOM;
	localparam int DRAIN_LIMIT = 100;

	logic clk;
	logic rst_i;
	logic in_valid_i;
	logic in_ready_o;
	alu_op_t in_op_i;
	logic [127:0] in_a_i;
	logic [127:0] in_b_i;
	logic [3:0] in_mask_i;
	logic in_broadcast_i;
	logic out_valid_o;
	logic out_ready_i = 1'b1;
	logic [127:0] out_result_o;
	logic [3:0] out_cmp_mask_o;

	logic [131:0] exp_q[$];
	string name_q[$];
	int cycle_q[$];
	int cycle = 0;
	int sent = 0;
	int outputs_seen = 0;
	logic stall_enable = 1'b0;
	logic [31:0] stim_rng = 32'd44;
	logic [31:0] stall_rng = 32'd44;
	logic holding = 1'b0;
	logic [127:0] held_result;

	alu_op_t op_table [0:23] = '{OP_OR, OP_AND, OP_UMINUS, OP_XOR, OP_NOT, OP_IADD,
		OP_ISUB, OP_ASR, OP_LSR, OP_LSL, OP_CLZ, OP_CTZ, OP_COPY, OP_EQUAL, OP_NEQUAL,
		OP_SIGTR, OP_SIGTE, OP_SILT, OP_SILTE, OP_UIGTR, OP_UIGTE, OP_UILT, OP_UILTE,
		OP_FTOI};

	vector_alu_top UUT(
		.clk(clk),
		.rst_i(rst_i),
		.in_valid_i(in_valid_i),
		.in_ready_o(in_ready_o),
		.in_op_i(in_op_i),
		.in_a_i(in_a_i),
		.in_b_i(in_b_i),
		.in_mask_i(in_mask_i),
		.in_broadcast_i(in_broadcast_i),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.out_result_o(out_result_o),
		.out_cmp_mask_o(out_cmp_mask_o));

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual)
		begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// Holds the instruction until the handshake completes, then queues its result
	task automatic send(input string name, input alu_op_t op, input logic [127:0] a,
		input logic [127:0] b, input logic [3:0] mask, input logic bcast);
		logic done;
		done = 1'b0;
		in_valid_i <= 1'b1;
		in_op_i <= op;
		in_a_i <= a;
		in_b_i <= b;
		in_mask_i <= mask;
		in_broadcast_i <= bcast;
		while (!done)
		begin
			@(negedge clk);
			// Without output stalls the DUT takes one instruction every cycle
			if (!stall_enable)
				check({name, " input ready"}, 128'(1), 128'(in_ready_o));
			if (in_ready_o)
			begin
				exp_q.push_back(vector_model(op, a, b, mask, bcast));
				name_q.push_back(name);
				cycle_q.push_back(cycle);
				sent++;
				done = 1'b1;
			end
			@(posedge clk);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = !clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	always @(posedge clk)
	begin
		if (stall_enable)
		begin
			stall_rng = xorshift32(stall_rng);
			out_ready_i <= stall_rng[0] | stall_rng[1];
		end
		else
			out_ready_i <= 1'b1;
	end

	// Outputs are sampled at the falling edge, half a cycle away from any change
	always @(negedge clk)
	begin
		logic [131:0] expected;
		string name;
		int acc_cycle;
		if (!rst_i)
		begin
			if (holding && out_valid_o)
				check("stalled output hold", held_result, out_result_o);
			if (out_valid_o && out_ready_i)
			begin
				if (exp_q.size() == 0)
					report_error("The DUT produced an output with no instruction pending");
				else
				begin
					expected = exp_q.pop_front();
					name = name_q.pop_front();
					acc_cycle = cycle_q.pop_front();
					check({name, " result"}, expected[127:0], out_result_o);
					check({name, " compare mask"}, 128'(expected[131:128]),
						128'(out_cmp_mask_o));
					if (!stall_enable)
						check({name, " latency"}, 128'(2), 128'(cycle - acc_cycle));
					outputs_seen++;
					holding = 1'b0;
				end
			end
			else if (out_valid_o)
			begin
				held_result = out_result_o;
				holding = 1'b1;
			end
		end
	end

	initial
	begin
		#((TOTAL * 20 + 100) * 100);
		report_error("Watchdog timeout, the DUT stopped producing results");
	end

	initial
	begin
		alu_op_t op;
		logic [127:0] a;
		logic [127:0] b;
		logic [3:0] mask;
		logic bcast;
		int drain_cycles;
		rst_i = 1'b1;
		in_valid_i = 1'b0;
		in_op_i = OP_OR;
		in_a_i = '0;
		in_b_i = '0;
		in_mask_i = '0;
		in_broadcast_i = 1'b0;
		repeat (4) @(posedge clk);
		rst_i <= 1'b0;
		@(posedge clk);

		// Every opcode back to back, full mask
		for (int i = 0; i < NUM_DIRECTED; i++)
		begin
			op = op_table[i];
			a = {32'h12345678, 32'hffffffff, 32'h80000000, 32'h00000005};
			b = {32'h0f0f0f0f, 32'h00000001, 32'h80000000, 32'hfffffffd};
			if (op inside {OP_ASR, OP_LSR, OP_LSL})
			begin
				a = {32'h80000000, 32'hf0000001, 32'h12345678, 32'h80000010};
				b = {32'd4, 32'd31, 32'd32, 32'h00010003};
			end
			else if (op inside {OP_CLZ, OP_CTZ})
				b = {32'h0, 32'h1, 32'h80000000, 32'h00f00000};
			else if (op >= OP_EQUAL && op <= OP_UILTE)
			begin
				a = {32'h5, 32'h80000000, 32'h7fffffff, 32'hffffffff};
				b = {32'h5, 32'h7fffffff, 32'h80000000, 32'h0};
			end
			else if (op == OP_FTOI)
				b = {32'h0, 32'h3f000000, 32'h40700000, 32'hc1000000};
			send(op.name(), op, a, b, 4'hf, 1'b0);
		end
		in_valid_i <= 1'b0;
		while (outputs_seen < sent)
			@(posedge clk);
		stall_enable <= 1'b1;

		// Random opcodes, masks, broadcast and operands with output stalls
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			stim_rng = xorshift32(stim_rng);
			op = op_table[stim_rng % 24];
			mask = stim_rng[11:8];
			bcast = stim_rng[12] & stim_rng[13];
			for (int lane = 0; lane < 4; lane++)
			begin
				stim_rng = xorshift32(stim_rng);
				a[lane*32 +: 32] = stim_rng;
				stim_rng = xorshift32(stim_rng);
				case (stim_rng[1:0])
					2'd0: b[lane*32 +: 32] = a[lane*32 +: 32];
					2'd1: b[lane*32 +: 32] = 32'h80000000;
					2'd2: b[lane*32 +: 32] = 32'h7fffffff;
					default: b[lane*32 +: 32] = xorshift32(stim_rng);
				endcase
				if (op == OP_FTOI)
					b[lane*32 +: 32] = {stim_rng[31], 8'(120 + stim_rng[15:2] % 38),
						stim_rng[30:8]};
				else if (op inside {OP_ASR, OP_LSR, OP_LSL} && stim_rng[2])
					b[lane*32 +: 32] = {27'd0, stim_rng[7:3]};
			end
			send($sformatf("random %0d %s", i, op.name()), op, a, b, mask, bcast);
		end
		in_valid_i <= 1'b0;

		// A result that never comes out stays in the queue after the drain limit
		drain_cycles = 0;
		while (outputs_seen < sent && drain_cycles < DRAIN_LIMIT)
		begin
			@(posedge clk);
			drain_cycles++;
		end
		repeat (4) @(posedge clk);

		if (exp_q.size() != 0)
			report_error("Expected results were left over at the end of the run");
		else
		begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

//--- hw/vector_alu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-lane vector integer ALU
// Two register stages deep with one instruction per cycle throughput
// Both handshakes are valid/ready and a stall at the output reaches
// in_ready_o in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vector_alu_config.svh"

module vector_alu_top(
	input clk,
	input rst_i,
	input in_valid_i,
	output logic in_ready_o,
	input alu_op_pkg::alu_op_t in_op_i,
	input [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] in_a_i,
	input [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] in_b_i,
	input [`VALU_NUM_LANES-1:0] in_mask_i,
	input in_broadcast_i,
	output logic out_valid_o,
	input out_ready_i,
	output logic [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] out_result_o,
	output logic [`VALU_NUM_LANES-1:0] out_cmp_mask_o);

	import alu_op_pkg::*;
	import vector_types_pkg::*;

	logic iss_valid;
	logic iss_ready;
	alu_op_t iss_op;
	logic [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] iss_a;
	logic [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] iss_b;
	logic [`VALU_NUM_LANES-1:0] iss_mask;
	logic [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] lane_result;

	vector_operand_issue issue_stage(
		.clk(clk),
		.rst_i(rst_i),
		.in_valid_i(in_valid_i),
		.in_ready_o(in_ready_o),
		.in_op_i(in_op_i),
		.in_a_i(in_a_i),
		.in_b_i(in_b_i),
		.in_mask_i(in_mask_i),
		.in_broadcast_i(in_broadcast_i),
		.iss_valid_o(iss_valid),
		.iss_ready_i(iss_ready),
		.iss_op_o(iss_op),
		.iss_a_o(iss_a),
		.iss_b_o(iss_b),
		.iss_mask_o(iss_mask));

	genvar lane;
	generate
		for (lane = 0; lane < `VALU_NUM_LANES; lane++)
		begin : gen_lane
			fp_word_u lane_b;

			assign lane_b = iss_b[lane*`VALU_WORD_WIDTH +: `VALU_WORD_WIDTH];

			single_cycle_scalar_alu lane_alu(
				.operation_i(iss_op),
				.operand1_i(iss_a[lane*`VALU_WORD_WIDTH +: `VALU_WORD_WIDTH]),
				.operand2_i(lane_b),
				.result_o(lane_result[lane*`VALU_WORD_WIDTH +: `VALU_WORD_WIDTH]));
		end
	endgenerate

	vector_result_collect collect_stage(
		.clk(clk),
		.rst_i(rst_i),
		.iss_valid_i(iss_valid),
		.iss_ready_o(iss_ready),
		.iss_op_i(iss_op),
		.iss_a_i(iss_a),
		.iss_mask_i(iss_mask),
		.lane_result_i(lane_result),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.out_result_o(out_result_o),
		.out_cmp_mask_o(out_cmp_mask_o));

endmodule

//--- hw/vector_result_collect.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result register behind the lane ALUs
// Masked-off lanes return operand 1 unchanged
// The compare mask is nonzero only for comparison opcodes
// Outputs hold steady while valid is high and the sink is not ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vector_alu_config.svh"

module vector_result_collect(
	input clk,
	input rst_i,
	input iss_valid_i,
	output logic iss_ready_o,
	input alu_op_pkg::alu_op_t iss_op_i,
	input [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] iss_a_i,
	input [`VALU_NUM_LANES-1:0] iss_mask_i,
	input [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] lane_result_i,
	output logic out_valid_o,
	input out_ready_i,
	output logic [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] out_result_o,
	output logic [`VALU_NUM_LANES-1:0] out_cmp_mask_o);

	import alu_op_pkg::*;

	logic [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] merged;
	logic [`VALU_NUM_LANES-1:0] lane_lsb;
	logic [`VALU_NUM_LANES-1:0] cmp_mask;
	logic load;

	assign iss_ready_o = !out_valid_o || out_ready_i;
	assign load = iss_valid_i && iss_ready_o;

	always_comb
	begin
		for (int lane = 0; lane < `VALU_NUM_LANES; lane++)
		begin
			if (iss_mask_i[lane])
				merged[lane*`VALU_WORD_WIDTH +: `VALU_WORD_WIDTH] =
					lane_result_i[lane*`VALU_WORD_WIDTH +: `VALU_WORD_WIDTH];
			else
				merged[lane*`VALU_WORD_WIDTH +: `VALU_WORD_WIDTH] =
					iss_a_i[lane*`VALU_WORD_WIDTH +: `VALU_WORD_WIDTH];
			lane_lsb[lane] = lane_result_i[lane*`VALU_WORD_WIDTH];
		end
	end

	// Bit 0 of a comparison lane is its true/false flag
	assign cmp_mask = is_compare_op(iss_op_i) ? (lane_lsb & iss_mask_i) : '0;

	always_ff @(posedge clk)
	begin
		if (rst_i)
			out_valid_o <= 1'b0;
		else if (iss_ready_o)
			out_valid_o <= iss_valid_i;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			out_result_o <= merged;
			out_cmp_mask_o <= cmp_mask;
		end
	end

	// A stalled result stays valid and unchanged until the sink takes it
	a_result_held_on_stall: assert property (@(posedge clk) disable iff (rst_i)
		(out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_result_o)));

endmodule

//--- hw/vector_operand_issue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue register in front of the lane ALUs
// Accepts one instruction per cycle through a valid/ready handshake
// The source must hold its inputs while valid is high and ready low
// Broadcast copies lane 0 of operand 2 to every lane on load
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vector_alu_config.svh"

module vector_operand_issue(
	input clk,
	input rst_i,
	input in_valid_i,
	output logic in_ready_o,
	input alu_op_pkg::alu_op_t in_op_i,
	input [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] in_a_i,
	input [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] in_b_i,
	input [`VALU_NUM_LANES-1:0] in_mask_i,
	input in_broadcast_i,
	output logic iss_valid_o,
	input iss_ready_i,
	output alu_op_pkg::alu_op_t iss_op_o,
	output logic [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] iss_a_o,
	output logic [`VALU_NUM_LANES*`VALU_WORD_WIDTH-1:0] iss_b_o,
	output logic [`VALU_NUM_LANES-1:0] iss_mask_o);

	import vector_types_pkg::*;

	lane_word_t bcast_word;
	logic accept;

	// The stage frees up in the same cycle that collect takes its contents
	assign in_ready_o = !iss_valid_o || iss_ready_i;
	assign accept = in_valid_i && in_ready_o;
	assign bcast_word = in_b_i[`VALU_WORD_WIDTH-1:0];

	always_ff @(posedge clk)
	begin
		if (rst_i)
			iss_valid_o <= 1'b0;
		else if (in_ready_o)
			iss_valid_o <= in_valid_i;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			iss_op_o <= in_op_i;
			iss_a_o <= in_a_i;
			iss_mask_o <= in_mask_i;
			if (in_broadcast_i)
				iss_b_o <= {`VALU_NUM_LANES{bcast_word}};
			else
				iss_b_o <= in_b_i;
		end
	end

	// A stalled source keeps its opcode until the transfer happens
	a_op_held_on_stall: assert property (@(posedge clk) disable iff (rst_i)
		(in_valid_i && !in_ready_o) |=> $stable(in_op_i));

	// Once out of reset the stage valid always has a defined value
	a_valid_known: assert property (@(posedge clk) disable iff (rst_i)
		!$isunknown(iss_valid_o));

endmodule

//--- hw/single_cycle_scalar_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One lane of integer ALU work, purely combinational
// Shift counts above 31 saturate to the fill value
// FTOI truncates toward zero and is exact for exponents below 158
// Larger magnitudes wrap and are not meaningful
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module single_cycle_scalar_alu(
	input alu_op_pkg::alu_op_t operation_i,
	input vector_types_pkg::lane_word_t operand1_i,
	input vector_types_pkg::fp_word_u operand2_i,
	output vector_types_pkg::lane_word_t result_o);

	import alu_op_pkg::*;
	import vector_types_pkg::*;

	lane_word_t op2;
	logic is_sub;
	logic [32:0] add_result;
	lane_word_t sum_diff;
	logic borrow;
	logic negative;
	logic overflow;
	logic zero;
	logic signed_ge;
	lane_word_t tz_scan;
	lane_word_t lz_scan;
	logic [4:0] tz_count;
	logic [4:0] lz_count;
	logic [7:0] fp_exp;
	logic [23:0] fp_mant;
	logic is_ftoi;
	logic [4:0] rshift_amt;
	lane_word_t rshift_in;
	logic rshift_fill;
	lane_word_t rshift_out;
	lane_word_t ftoi_lshift;
	lane_word_t ftoi_mag;
	logic shift_saturate;

	assign op2 = operand2_i.word;

	// Every opcode except IADD runs the chain as a subtract
	assign is_sub = operation_i != OP_IADD;
	assign add_result = {1'b0, operand1_i} + {is_sub, op2 ^ {32{is_sub}}} + 33'(is_sub);
	assign sum_diff = add_result[31:0];

	// Bit 32 of a subtract is set when operand 1 is below operand 2 unsigned
	assign borrow = add_result[32];
	assign negative = sum_diff[31];
	assign overflow = (operand1_i[31] != op2[31]) && (negative == op2[31]);
	assign zero = sum_diff == '0;
	assign signed_ge = overflow == negative;

	// Trailing zeroes by halving the window from the low end
	always_comb
	begin
		tz_scan = op2;
		for (int step = 4; step >= 0; step--)
		begin
			tz_count[step] = (tz_scan & ((32'd1 << (1 << step)) - 32'd1)) == '0;
			if (tz_count[step])
				tz_scan = tz_scan >> (1 << step);
		end
	end

	// Leading zeroes by halving the window from the high end
	always_comb
	begin
		lz_scan = op2;
		for (int step = 4; step >= 0; step--)
		begin
			lz_count[step] = (lz_scan >> (32 - (1 << step))) == '0;
			if (lz_count[step])
				lz_scan = lz_scan << (1 << step);
		end
	end

	assign fp_exp = operand2_i.fp.exponent;
	assign fp_mant = {1'b1, operand2_i.fp.fraction};
	assign is_ftoi = operation_i == OP_FTOI;

	// FTOI borrows the right shifter to drop the bits below the binary point
	assign rshift_amt = is_ftoi ? 5'(8'd150 - fp_exp) : op2[4:0];
	assign rshift_in = is_ftoi ? {8'h00, fp_mant} : operand1_i;
	assign rshift_fill = (operation_i == OP_ASR) && operand1_i[31];
	assign rshift_out = 32'({{32{rshift_fill}}, rshift_in} >> rshift_amt);

	// An exponent above 150 leaves no fraction bits and moves the mantissa up
	assign ftoi_lshift = {8'h00, fp_mant} << 5'(fp_exp - 8'd150);
	assign ftoi_mag = (fp_exp > 8'd150) ? ftoi_lshift : rshift_out;

	assign shift_saturate = op2[31:5] != '0;

	always_comb
	begin
		case (operation_i)
			OP_OR: result_o = operand1_i | op2;
			OP_AND: result_o = operand1_i & op2;
			OP_UMINUS: result_o = -op2;
			OP_XOR: result_o = operand1_i ^ op2;
			OP_NOT: result_o = ~op2;
			OP_IADD,
			OP_ISUB: result_o = sum_diff;
			OP_ASR,
			OP_LSR: result_o = shift_saturate ? {32{rshift_fill}} : rshift_out;
			OP_LSL: result_o = shift_saturate ? '0 : operand1_i << op2[4:0];
			OP_CLZ: result_o = (op2 == '0) ? 32'd32 : {27'h0, lz_count};
			OP_CTZ: result_o = (op2 == '0) ? 32'd32 : {27'h0, tz_count};
			OP_COPY: result_o = op2;
			OP_EQUAL: result_o = {31'h0, zero};
			OP_NEQUAL: result_o = {31'h0, !zero};
			OP_SIGTR: result_o = {31'h0, signed_ge && !zero};
			OP_SIGTE: result_o = {31'h0, signed_ge};
			OP_SILT: result_o = {31'h0, !signed_ge};
			OP_SILTE: result_o = {31'h0, !signed_ge || zero};
			OP_UIGTR: result_o = {31'h0, !borrow && !zero};
			OP_UIGTE: result_o = {31'h0, !borrow};
			OP_UILT: result_o = {31'h0, borrow};
			OP_UILTE: result_o = {31'h0, borrow || zero};
			OP_FTOI:
			begin
				// Magnitudes below one, zero included, truncate to 0
				if (fp_exp < 8'd127)
					result_o = '0;
				else if (operand2_i.fp.sign)
					result_o = -ftoi_mag;
				else
					result_o = ftoi_mag;
			end
			default: result_o = '0;
		endcase
	end

endmodule

//--- hw/vector_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word types of one vector lane
// The float view follows IEEE 754 single precision and only lines
// up with the integer view for 32-bit words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vector_alu_config.svh"

package vector_types_pkg;

	typedef logic [`VALU_WORD_WIDTH-1:0] lane_word_t;

	// Single-precision fields, most significant first
	typedef struct packed
	{
		logic sign;
		logic [7:0] exponent;
		logic [22:0] fraction;
	} fp_fields_t;

	// An operand word read as an integer or as a float
	typedef union packed
	{
		lane_word_t word;
		fp_fields_t fp;
	} fp_word_u;

endpackage

//--- hw/alu_op_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcodes of the single-cycle integer ALU
// Encodings not listed here make every lane return 0
// Multiply and float add are executed elsewhere and have no codes here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vector_alu_config.svh"

package alu_op_pkg;

	// Gaps in the encoding belong to the multi-cycle operations
	typedef enum logic [`VALU_OP_WIDTH-1:0]
	{
		OP_OR     = 6'h00,
		OP_AND    = 6'h01,
		OP_UMINUS = 6'h02,
		OP_XOR    = 6'h03,
		OP_NOT    = 6'h04,
		OP_IADD   = 6'h05,
		OP_ISUB   = 6'h06,
		OP_ASR    = 6'h09,
		OP_LSR    = 6'h0a,
		OP_LSL    = 6'h0b,
		OP_CLZ    = 6'h0c,
		OP_CTZ    = 6'h0e,
		OP_COPY   = 6'h0f,
		OP_EQUAL  = 6'h10,
		OP_NEQUAL = 6'h11,
		OP_SIGTR  = 6'h12,
		OP_SIGTE  = 6'h13,
		OP_SILT   = 6'h14,
		OP_SILTE  = 6'h15,
		OP_UIGTR  = 6'h16,
		OP_UIGTE  = 6'h17,
		OP_UILT   = 6'h18,
		OP_UILTE  = 6'h19,
		OP_FTOI   = 6'h1b
	} alu_op_t;

	// Comparisons return 0 or 1 in bit 0 of the lane result
	function automatic logic is_compare_op(alu_op_t op);
		return op inside {OP_EQUAL, OP_NEQUAL, OP_SIGTR, OP_SIGTE, OP_SILT,
			OP_SILTE, OP_UIGTR, OP_UIGTE, OP_UILT, OP_UILTE};
	endfunction

endpackage

//--- hw/vector_alu_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build-time sizing of the vector ALU
// The lane datapath and its float view are built for 32-bit words
// so VALU_WORD_WIDTH has to stay at 32
// Lane vectors are flat with lane 0 in the low word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef VECTOR_ALU_CONFIG_SVH
`define VECTOR_ALU_CONFIG_SVH

// Number of lanes that execute one vector instruction together
`define VALU_NUM_LANES 4

// Width of one lane word
`define VALU_WORD_WIDTH 32

// Width of the opcode field
`define VALU_OP_WIDTH 6

`endif
